/* Bender.yml */
package:
  name: spi_loader

sources:
  - files:
      - rtl/flash_loader_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/cmd_sequencer.sv
      - rtl/spi_frame_tx.sv
      - rtl/spi_loader_top.sv
  - target: simulation
    files:
      - sim/spi_loader_props.sv
      - sim/spi_loader_tb.sv

/* build.f */
rtl/flash_loader_pkg.sv
rtl/sync_fifo.sv
rtl/cmd_sequencer.sv
rtl/spi_frame_tx.sv
rtl/spi_loader_top.sv
sim/spi_loader_props.sv
sim/spi_loader_tb.sv

/* rtl/cmd_sequencer.sv */
`timescale 1ns/100ps

module cmd_sequencer (
    input  logic                         CLK_I,
    input  logic                         SRST_I,
    input  flash_loader_pkg::cmd_req_t   cmd_head,
    input  logic                         cmd_empty,
    input  logic                         frame_busy,
    output logic                         cmd_pop,
    output logic                         frame_start,
    output flash_loader_pkg::frame_req_t frame_req
);

    typedef enum logic [2:0] {
        IDLE_S,         // Wait for a queued command
        GET_S,          // Capture head and pop
        PARSE_S,        // Drop unsupported codes
        WREN_S,         // Issue write-enable frame
        WREN_WAIT_S,
        OP_S,           // Issue erase or program frame
        OP_WAIT_S       // Step to next unit or finish
    } state_t;

    state_t                  state;
    flash_loader_pkg::cmd_t  cur_cmd;
    flash_loader_pkg::addr_t cur_addr;
    flash_loader_pkg::addr_t step;
    logic [15:0]             units_left;
    logic [15:0]             head_units;
    logic [7:0]              op_code;
    logic                    last_unit;

    ////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////

    // Unit count of the head entry, zero counts as one
    always_comb begin
        if (cmd_head.cmd == flash_loader_pkg::WRITE_DATA)
            head_units = cmd_head.page_count;
        else
            head_units = {8'h00, cmd_head.sector_count};
        if (cmd_head.cmd == flash_loader_pkg::ERASE_CHIP || head_units == '0)
            head_units = 16'd1;        // Chip erase is a single frame
    end

    // Address step and opcode per command
    always_comb begin
        case (cur_cmd)
            flash_loader_pkg::ERASE_SUB: begin
                step    = flash_loader_pkg::addr_t'(flash_loader_pkg::SUBSECTOR_BYTES);
                op_code = flash_loader_pkg::OP_SUBSECTOR_ERASE;
            end
            flash_loader_pkg::ERASE_SEC: begin
                step    = flash_loader_pkg::addr_t'(flash_loader_pkg::SECTOR_BYTES);
                op_code = flash_loader_pkg::OP_SECTOR_ERASE;
            end
            flash_loader_pkg::ERASE_CHIP: begin
                step    = '0;          // Never stepped
                op_code = flash_loader_pkg::OP_BULK_ERASE;
            end
            default: begin
                step    = flash_loader_pkg::addr_t'(flash_loader_pkg::PAGE_BYTES);
                op_code = flash_loader_pkg::OP_PAGE_PROGRAM;
            end
        endcase
    end

    assign last_unit = (units_left == 16'd1);

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_ff @(posedge CLK_I) begin
        if (SRST_I) begin
            state <= IDLE_S;
        end else begin
            case (state)
                IDLE_S:      if (!cmd_empty) state <= GET_S;
                GET_S:       state <= PARSE_S;
                PARSE_S:     state <= cur_cmd[2] ? IDLE_S : WREN_S;   // 4 to 7 dropped
                WREN_S:      if (!frame_busy) state <= WREN_WAIT_S;
                WREN_WAIT_S: if (!frame_busy) state <= OP_S;
                OP_S:        if (!frame_busy) state <= OP_WAIT_S;
                OP_WAIT_S:   if (!frame_busy) state <= last_unit ? IDLE_S : WREN_S;
                default:     state <= IDLE_S;
            endcase
        end
    end

    // Working copy of the command
    always_ff @(posedge CLK_I) begin
        if (state == GET_S) begin
            cur_cmd    <= cmd_head.cmd;
            cur_addr   <= cmd_head.start_addr;
            units_left <= head_units;
        end else if (state == OP_WAIT_S && !frame_busy && !last_unit) begin
            cur_addr   <= cur_addr + step;     // Next subsector, sector or page
            units_left <= units_left - 1'b1;
        end
    end

    assign cmd_pop     = (state == GET_S);
    assign frame_start = (state == WREN_S || state == OP_S) && !frame_busy;

    // Frame descriptor
    always_comb begin
        frame_req.addr = cur_addr;
        if (state == WREN_S) begin
            frame_req.opcode      = flash_loader_pkg::OP_WREN;   // Opcode only
            frame_req.has_addr    = 1'b0;
            frame_req.has_payload = 1'b0;
        end else begin
            frame_req.opcode      = op_code;
            frame_req.has_addr    = (cur_cmd != flash_loader_pkg::ERASE_CHIP);
            frame_req.has_payload = (cur_cmd == flash_loader_pkg::WRITE_DATA);
        end
    end

endmodule

/* rtl/flash_loader_pkg.sv */
package flash_loader_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int ADDR_W          = 24;    // Three-byte addressing
    localparam int PAGE_BYTES      = 256;   // Program unit
    localparam int SUBSECTOR_BYTES = 4096;  // Subsector erase unit
    localparam int SECTOR_BYTES    = 65536; // Sector erase unit

    // Queue sizes
    localparam int CMD_FIFO_DEPTH  = 4;
    localparam int CMD_FIFO_PFULL  = 3;     // Host sees full one entry early
    localparam int DATA_FIFO_DEPTH = 512;   // Two pages of payload
    localparam int DATA_FIFO_PFULL = 384;

    typedef logic [ADDR_W-1:0] addr_t;

    ////////////////////////////////////////
    // Host command codes
    ////////////////////////////////////////
    typedef logic [2:0] cmd_t;

    localparam cmd_t ERASE_SUB  = 3'd0;
    localparam cmd_t ERASE_SEC  = 3'd1;
    localparam cmd_t ERASE_CHIP = 3'd2;
    localparam cmd_t WRITE_DATA = 3'd3;
    // Codes 4 to 7 are popped and dropped

    // Flash opcodes
    localparam logic [7:0] OP_WREN            = 8'h06;
    localparam logic [7:0] OP_SUBSECTOR_ERASE = 8'h20;
    localparam logic [7:0] OP_SECTOR_ERASE    = 8'hD8;
    localparam logic [7:0] OP_BULK_ERASE      = 8'hC7;
    localparam logic [7:0] OP_PAGE_PROGRAM    = 8'h02;

    ////////////////////////////////////////
    // Shared records
    ////////////////////////////////////////
    typedef struct packed {
        cmd_t        cmd;           // Operation
        addr_t       start_addr;    // First byte touched
        logic [15:0] page_count;    // Pages for a write
        logic [7:0]  sector_count;  // Units for an erase
    } cmd_req_t;

    typedef struct packed {
        logic [7:0] opcode;         // Always the first byte on the wire
        logic       has_addr;       // Three address bytes follow
        addr_t      addr;
        logic       has_payload;    // One page from the payload FIFO
    } frame_req_t;

endpackage

/* rtl/spi_frame_tx.sv */
`timescale 1ns/100ps

module spi_frame_tx (
    input  logic                         CLK_I,
    input  logic                         SRST_I,
    input  logic                         frame_start,
    input  flash_loader_pkg::frame_req_t frame_req,
    input  logic [7:0]                   pay_data,
    input  logic                         pay_empty,
    output logic                         frame_busy,
    output logic                         pay_rd,
    output logic                         spi_sck,
    output logic                         spi_cs_n,
    output logic                         spi_mosi
);

    typedef logic [$clog2(flash_loader_pkg::PAGE_BYTES + 1)-1:0] pay_cnt_t;

    logic [7:0]              shift_reg;  // Byte on the wire, MSB first
    flash_loader_pkg::addr_t addr_sr;    // Address bytes still to send
    logic [1:0]              hdr_left;   // Address bytes after current one
    pay_cnt_t                pay_left;   // Payload bytes not yet loaded
    logic [2:0]              bit_cnt;
    logic                    wait_pay;   // Stalled on empty payload FIFO
    logic                    byte_end;
    logic                    pay_due;

    // Last high phase of a byte
    assign byte_end = frame_busy && spi_sck && (bit_cnt == 3'd7);

    // Payload byte wanted now
    assign pay_due  = wait_pay || (byte_end && hdr_left == 2'd0 && pay_left != '0);
    assign pay_rd   = pay_due && !pay_empty;
    assign spi_mosi = shift_reg[7];

    ////////////////////////////////////////
    // Bit and byte sequencing
    ////////////////////////////////////////
    always_ff @(posedge CLK_I) begin
        if (SRST_I) begin
            frame_busy <= 1'b0;
            spi_cs_n   <= 1'b1;
            spi_sck    <= 1'b0;
            shift_reg  <= '0;
            hdr_left   <= '0;
            pay_left   <= '0;
            bit_cnt    <= '0;
            wait_pay   <= 1'b0;
        end else if (!frame_busy) begin
            if (frame_start) begin
                frame_busy <= 1'b1;
                spi_cs_n   <= 1'b0;            // First bit valid with CS
                spi_sck    <= 1'b0;
                bit_cnt    <= '0;
                wait_pay   <= 1'b0;
                shift_reg  <= frame_req.opcode;
                hdr_left   <= frame_req.has_addr ? 2'd3 : 2'd0;
                pay_left   <= frame_req.has_payload ?
                              pay_cnt_t'(flash_loader_pkg::PAGE_BYTES) : '0;
            end
        end else if (wait_pay) begin
            // SCK held low, CS stays asserted
            if (!pay_empty) begin
                wait_pay  <= 1'b0;
                shift_reg <= pay_data;
                pay_left  <= pay_left - 1'b1;
            end
        end else if (!spi_sck) begin
            spi_sck <= 1'b1;                   // Flash samples here
        end else begin
            spi_sck <= 1'b0;
            bit_cnt <= bit_cnt + 1'b1;         // Wraps at byte end
            if (bit_cnt != 3'd7) begin
                shift_reg <= {shift_reg[6:0], 1'b0};
            end else if (hdr_left != 2'd0) begin
                shift_reg <= addr_sr[23:16];   // Next address byte
                hdr_left  <= hdr_left - 1'b1;
            end else if (pay_left != '0) begin
                if (pay_empty) begin
                    wait_pay <= 1'b1;
                end else begin
                    shift_reg <= pay_data;
                    pay_left  <= pay_left - 1'b1;
                end
            end else begin
                frame_busy <= 1'b0;            // Frame done
                spi_cs_n   <= 1'b1;
            end
        end
    end

    // Address bytes, high byte first
    always_ff @(posedge CLK_I) begin
        if (!frame_busy && frame_start)
            addr_sr <= frame_req.addr;
        else if (byte_end && hdr_left != 2'd0)
            addr_sr <= {addr_sr[15:0], 8'h00};
    end

endmodule

/* rtl/spi_loader_top.sv */
`timescale 1ns/100ps

module spi_loader_top (
    input  logic                       CLK_I,
    input  logic                       SRST_I,
    input  logic                       cmd_dvi,
    input  flash_loader_pkg::cmd_req_t cmd_req,
    input  logic                       data_dvi,
    input  logic [7:0]                 data_to_prog,
    output logic                       cmd_fifo_empty,
    output logic                       cmd_fifo_full,
    output logic                       data_fifo_pfull,
    output logic                       spi_sck,
    output logic                       spi_cs_n,
    output logic                       spi_mosi
);

    // Command queue to sequencer
    flash_loader_pkg::cmd_req_t   cmd_head;
    logic                         cmd_pop;

    // Sequencer to shifter
    logic                         frame_start;
    flash_loader_pkg::frame_req_t frame_req;
    logic                         frame_busy;

    // Payload queue to shifter
    logic [7:0]                   pay_data;
    logic                         pay_empty;
    logic                         pay_rd;

    ////////////////////////////////////////
    // Host queues
    ////////////////////////////////////////
    sync_fifo #(
        .WIDTH ( $bits(flash_loader_pkg::cmd_req_t) ),
        .DEPTH ( flash_loader_pkg::CMD_FIFO_DEPTH   ),
        .PFULL ( flash_loader_pkg::CMD_FIFO_PFULL   )
    ) cmd_fifo_i (
        .CLK_I  ( CLK_I          ),
        .SRST_I ( SRST_I         ),
        .wr_en  ( cmd_dvi        ),
        .din    ( cmd_req        ),
        .rd_en  ( cmd_pop        ),
        .dout   ( cmd_head       ),
        .empty  ( cmd_fifo_empty ),
        .full   (                ),   // Host flow control uses pfull
        .pfull  ( cmd_fifo_full  )
    );

    sync_fifo #(
        .WIDTH ( 8                                 ),
        .DEPTH ( flash_loader_pkg::DATA_FIFO_DEPTH ),
        .PFULL ( flash_loader_pkg::DATA_FIFO_PFULL )
    ) data_fifo_i (
        .CLK_I  ( CLK_I           ),
        .SRST_I ( SRST_I          ),
        .wr_en  ( data_dvi        ),
        .din    ( data_to_prog    ),
        .rd_en  ( pay_rd          ),
        .dout   ( pay_data        ),
        .empty  ( pay_empty       ),
        .full   (                 ),
        .pfull  ( data_fifo_pfull )
    );

    ////////////////////////////////////////
    // Frame generation
    ////////////////////////////////////////
    cmd_sequencer cmd_sequencer_i (
        .CLK_I       ( CLK_I          ),
        .SRST_I      ( SRST_I         ),
        .cmd_head    ( cmd_head       ),
        .cmd_empty   ( cmd_fifo_empty ),
        .frame_busy  ( frame_busy     ),
        .cmd_pop     ( cmd_pop        ),
        .frame_start ( frame_start    ),
        .frame_req   ( frame_req      )
    );

    spi_frame_tx spi_frame_tx_i (
        .CLK_I       ( CLK_I       ),
        .SRST_I      ( SRST_I      ),
        .frame_start ( frame_start ),
        .frame_req   ( frame_req   ),
        .pay_data    ( pay_data    ),
        .pay_empty   ( pay_empty   ),
        .frame_busy  ( frame_busy  ),
        .pay_rd      ( pay_rd      ),
        .spi_sck     ( spi_sck     ),
        .spi_cs_n    ( spi_cs_n    ),
        .spi_mosi    ( spi_mosi    )
    );

endmodule

/* rtl/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16,   // Power of two, pointers wrap freely
    parameter int PFULL = 12
) (
    input  logic             CLK_I,
    input  logic             SRST_I,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             pfull
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;    // Fill level, 0 to DEPTH
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && !full;     // Drop writes when full
    assign do_rd = rd_en && !empty;

    // Storage
    always_ff @(posedge CLK_I) begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge CLK_I) begin
        if (SRST_I) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

    assign dout  = mem[rd_ptr];        // Head shows before the pop
    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));
    assign pfull = (count >= (AW+1)'(PFULL));

endmodule

/* sim/spi_loader_props.sv */
`timescale 1ns/100ps

module spi_loader_props (
    input logic CLK_I,
    input logic SRST_I,
    input logic spi_sck,
    input logic spi_cs_n,
    input logic pay_rd,
    input logic pay_empty,
    input logic frame_busy
);

    // SCK only toggles inside a frame
    sck_idle_low: assert property (@(posedge CLK_I) disable iff (SRST_I)
        spi_cs_n |-> !spi_sck)
        else $error("spi_sck high while spi_cs_n is released");

    // One-cycle read strobe, never on an empty FIFO
    pay_rd_guard: assert property (@(posedge CLK_I) disable iff (SRST_I)
        pay_rd |-> !pay_empty ##1 !pay_rd)
        else $error("pay_rd held past one cycle or raised on an empty payload FIFO");

    // Shifter idle straight out of reset
    busy_after_reset: assert property (@(posedge CLK_I) SRST_I |=> !frame_busy)
        else $error("frame_busy high one cycle after reset");

endmodule

bind spi_frame_tx spi_loader_props spi_loader_props_i (
    .CLK_I      ( CLK_I      ),
    .SRST_I     ( SRST_I     ),
    .spi_sck    ( spi_sck    ),
    .spi_cs_n   ( spi_cs_n   ),
    .pay_rd     ( pay_rd     ),
    .pay_empty  ( pay_empty  ),
    .frame_busy ( frame_busy )
);

/* sim/spi_loader_tb.sv */
`timescale 1ns/100ps

module spi_loader_tb;

    typedef struct packed {
        flash_loader_pkg::cmd_req_t req;
        logic [7:0]                 frames;     // Frames the command must produce
    } row_t;

    logic                       clk;
    logic                       srst;
    logic                       cmd_dvi;
    flash_loader_pkg::cmd_req_t cmd_req;
    logic                       data_dvi;
    logic [7:0]                 data_to_prog;
    logic                       cmd_fifo_empty;
    logic                       cmd_fifo_full;
    logic                       data_fifo_pfull;
    logic                       spi_sck;
    logic                       spi_cs_n;
    logic                       spi_mosi;

    row_t       main_tbl [7];
    row_t       burst_tbl [4];
    logic [7:0] exp_bytes [$];      // Expected wire bytes, all frames in order
    int         exp_len [$];        // Bytes per expected frame
    logic [7:0] pay_q [$];          // Payload still to push
    logic [7:0] got_q [$];          // Frame now on the wire
    logic [7:0] sh;
    int         nbit;
    logic       in_frame = 1'b0;
    int         frames_seen = 0;
    int         err_val = 0;
    int         err_misc = 0;
    int         seed = 57727;
    int         cycles = 0;
    int         limit = 4000;       // Reset and idle margin, grows with each frame

    spi_loader_top spi_loader_top_i (
        .CLK_I  ( clk  ),
        .SRST_I ( srst ),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // Payload pusher, backs off at the FIFO level
    initial begin
        data_dvi     = 1'b0;
        data_to_prog = '0;
        forever begin
            @(posedge clk);
            #2;
            if (pay_q.size() != 0 && !data_fifo_pfull) begin
                data_to_prog = pay_q.pop_front();
                data_dvi     = 1'b1;
            end else begin
                data_dvi = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Reference frame model
    ////////////////////////////////////////
    function automatic void add_frames(input flash_loader_pkg::cmd_req_t req);
        int          units;
        int          u;
        int          k;
        int          rnd;
        logic [23:0] a;
        logic [23:0] step;
        logic [7:0]  op;
        a     = req.start_addr;
        units = (req.cmd == flash_loader_pkg::WRITE_DATA) ? req.page_count : req.sector_count;
        if (units == 0 || req.cmd == flash_loader_pkg::ERASE_CHIP)
            units = 1;                  // Zero means one unit
        case (req.cmd)
            flash_loader_pkg::ERASE_SUB: begin
                op   = 8'h20;
                step = 24'd4096;
            end
            flash_loader_pkg::ERASE_SEC: begin
                op   = 8'hD8;
                step = 24'd65536;
            end
            flash_loader_pkg::ERASE_CHIP: begin
                op   = 8'hC7;
                step = 24'd0;
            end
            flash_loader_pkg::WRITE_DATA: begin
                op   = 8'h02;
                step = 24'd256;
            end
            default: return;            // Codes 4 to 7 never reach the bus
        endcase
        for (u = 0; u < units; u++) begin
            exp_bytes.push_back(8'h06);     // Write enable
            exp_len.push_back(1);
            exp_bytes.push_back(op);
            if (req.cmd == flash_loader_pkg::ERASE_CHIP) begin
                exp_len.push_back(1);
            end else begin
                exp_bytes.push_back(a[23:16]);
                exp_bytes.push_back(a[15:8]);
                exp_bytes.push_back(a[7:0]);
                exp_len.push_back(req.cmd == flash_loader_pkg::WRITE_DATA ? 260 : 4);
            end
            if (req.cmd == flash_loader_pkg::WRITE_DATA) begin
                for (k = 0; k < 256; k++) begin
                    rnd = $random(seed);
                    pay_q.push_back(rnd[7:0]);
                    exp_bytes.push_back(rnd[7:0]);
                end
            end
            a = a + step;
            limit += 16 * (1 + exp_len[$]) + 40;    // Both frames plus gaps
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            err_val++;
            $display("ERROR %s: expected %0h, got %0h", name, exp, got);
        end
    endtask

    function automatic void compare_frame();
        int         n;
        int         i;
        logic [7:0] e;
        frames_seen++;
        assert (exp_len.size() != 0) else begin
            err_misc++;
            $display("Frame %0d of %0d bytes was not expected", frames_seen, got_q.size());
        end
        if (exp_len.size() != 0) begin
            n = exp_len.pop_front();
            assert (got_q.size() == n) else begin
                err_val++;
                $display("ERROR spi_cs_n frame %0d length: expected %h, got %h",
                         frames_seen, n, got_q.size());
            end
            assert (nbit == 0) else begin
                err_misc++;
                $display("Frame %0d ended with %0d stray bits", frames_seen, nbit);
            end
            for (i = 0; i < n; i++) begin
                e = exp_bytes.pop_front();
                if (i < got_q.size()) begin
                    assert (got_q[i] == e) else begin
                        err_val++;
                        $display("ERROR spi_mosi frame %0d byte %0d: expected %h, got %h",
                                 frames_seen, i, e, got_q[i]);
                    end
                end
            end
        end
    endfunction

    ////////////////////////////////////////
    // SPI frame monitor
    ////////////////////////////////////////
    always @(negedge spi_cs_n) begin
        if (!srst) begin
            in_frame = 1'b1;
            nbit     = 0;
            got_q.delete();
        end
    end

    always @(posedge spi_sck) begin
        if (in_frame) begin
            sh = {sh[6:0], spi_mosi};   // MSB first
            nbit++;
            if (nbit == 8) begin
                got_q.push_back(sh);
                nbit = 0;
            end
        end
    end

    always @(posedge spi_cs_n) begin
        if (in_frame) begin
            in_frame = 1'b0;
            compare_frame();
        end
    end

    // Watchdog
    initial begin
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d frames still missing", cycles,
                 exp_len.size());
        $display("Errors: %0d value, %0d other", err_val, err_misc);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic send_cmd(input flash_loader_pkg::cmd_req_t req);
        cmd_req = req;
        cmd_dvi = 1'b1;
        @(posedge clk);
        #2;
        cmd_dvi = 1'b0;
    endtask

    // All frames out and command queue empty
    task automatic wait_idle();
        do begin
            @(posedge clk);
            #2;
        end while (exp_len.size() != 0 || !spi_cs_n || !cmd_fifo_empty);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int r;
        int total;
        srst    = 1'b1;
        cmd_dvi = 1'b0;
        cmd_req = '0;
        // cmd, start address, pages, sectors, expected frames
        main_tbl[0] = {flash_loader_pkg::ERASE_SUB,  24'h012000, 16'd0, 8'd2, 8'd4};
        main_tbl[1] = {flash_loader_pkg::ERASE_SEC,  24'h030000, 16'd0, 8'd1, 8'd2};
        main_tbl[2] = {flash_loader_pkg::ERASE_CHIP, 24'h000000, 16'd0, 8'd0, 8'd2};
        main_tbl[3] = {flash_loader_pkg::WRITE_DATA, 24'h040100, 16'd2, 8'd0, 8'd4};
        main_tbl[4] = {3'd5,                         24'h050000, 16'd1, 8'd1, 8'd0};
        main_tbl[5] = {flash_loader_pkg::ERASE_SUB,  24'h0FF000, 16'd0, 8'd2, 8'd4};
        main_tbl[6] = {flash_loader_pkg::ERASE_SEC,  24'h120000, 16'd0, 8'd0, 8'd2};
        // Back to back burst, write first so its payload can queue ahead
        burst_tbl[0] = {flash_loader_pkg::WRITE_DATA, 24'h200000, 16'd2, 8'd0, 8'd4};
        burst_tbl[1] = {flash_loader_pkg::ERASE_SUB,  24'h210000, 16'd0, 8'd1, 8'd2};
        burst_tbl[2] = {flash_loader_pkg::ERASE_CHIP, 24'h000000, 16'd0, 8'd0, 8'd2};
        burst_tbl[3] = {flash_loader_pkg::ERASE_SEC,  24'h220000, 16'd0, 8'd1, 8'd2};
        repeat (8) @(posedge clk);
        #2;
        srst = 1'b0;
        @(posedge clk);
        #2;
        check_value("spi_cs_n", spi_cs_n, 1);
        check_value("spi_sck", spi_sck, 0);
        check_value("cmd_fifo_empty", cmd_fifo_empty, 1);
        check_value("cmd_fifo_full", cmd_fifo_full, 0);
        check_value("data_fifo_pfull", data_fifo_pfull, 0);

        total = 0;
        for (r = 0; r < 7; r++) begin
            while (cmd_fifo_full) begin
                @(posedge clk);
                #2;
            end
            add_frames(main_tbl[r].req);
            total += main_tbl[r].frames;
            send_cmd(main_tbl[r].req);
        end
        wait_idle();
        check_value("frame count", frames_seen, total);

        // Payload queued with no write pending, then four commands at once
        for (r = 0; r < 4; r++)
            add_frames(burst_tbl[r].req);
        while (!data_fifo_pfull) begin
            @(posedge clk);
            #2;
        end
        check_value("data_fifo_pfull level", 512 - pay_q.size(), 384);
        check_value("frame count", frames_seen, total);   // Payload alone starts no frame
        for (r = 0; r < 4; r++) begin
            total += burst_tbl[r].frames;
            send_cmd(burst_tbl[r].req);
        end
        check_value("cmd_fifo_full", cmd_fifo_full, 1);
        wait_idle();
        check_value("frame count", frames_seen, total);
        check_value("cmd_fifo_full", cmd_fifo_full, 0);
        check_value("data_fifo_pfull", data_fifo_pfull, 0);

        $display("Errors: %0d value, %0d other", err_val, err_misc);
        if (err_val == 0 && err_misc == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
